//--- src/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// datapath sizes
`define MIPS_DATA_W     32 // data word
`define MIPS_REG_ADDR_W 5  // register index
`define MIPS_REG_COUNT  32 // architectural registers

// primary opcodes in instr[31:26]
`define OP_RTYPE 6'h00 // alu op picked by funct
`define OP_J     6'h02
`define OP_JAL   6'h03
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDI  6'h08
`define OP_SLTI  6'h0a
`define OP_ANDI  6'h0c
`define OP_ORI   6'h0d
`define OP_LUI   6'h0f
`define OP_LW    6'h23
`define OP_SW    6'h2b

// funct codes in instr[5:0] for r-type
`define FN_SLL 6'h00
`define FN_SRL 6'h02
`define FN_JR  6'h08
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_SLT 6'h2a

`endif

//--- src/mips_pkg.sv
`include "mips_config.svh"

package mips_pkg;

	////////////////////////////////////////
	// instruction word views
	////////////////////////////////////////

	typedef struct packed
	{
		logic [5:0]                  opcode;
		logic [`MIPS_REG_ADDR_W-1:0] rs;
		logic [`MIPS_REG_ADDR_W-1:0] rt;
		logic [`MIPS_REG_ADDR_W-1:0] rd;
		logic [4:0]                  shamt; // shift amount for sll/srl
		logic [5:0]                  funct;
	} instr_r_t;

	typedef struct packed
	{
		logic [5:0]                  opcode;
		logic [`MIPS_REG_ADDR_W-1:0] rs;
		logic [`MIPS_REG_ADDR_W-1:0] rt;
		logic [15:0]                 imm; // sign extended in decode
	} instr_i_t;

	typedef struct packed
	{
		logic [5:0]  opcode;
		logic [25:0] target; // word index inside the 256MB region
	} instr_j_t;

	// same 32 bits, three field layouts
	typedef union packed
	{
		instr_r_t r;
		instr_i_t i;
		instr_j_t j;
	} instr_u;

	////////////////////////////////////////
	// control groups
	////////////////////////////////////////

	typedef enum logic [3:0]
	{
		alu_add = 4'd0, // also address calc for lw/sw
		alu_sub = 4'd1, // beq/bne compare
		alu_and = 4'd2,
		alu_or  = 4'd3,
		alu_slt = 4'd4,
		alu_sll = 4'd5,
		alu_srl = 4'd6,
		alu_lui = 4'd7  // imm into upper half
	} alu_op_e;

	// consumed in execute
	typedef struct packed
	{
		logic    reg_dst;       // write rd instead of rt
		logic    alu_src;       // second operand is the immediate
		alu_op_e alu_op;
		logic    branch;
		logic    branch_ne;     // invert the zero test
		logic    jump;
		logic    jump_register;
		logic    link;          // jal writes the return address
	} exec_ctrl_t;

	typedef struct packed
	{
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	typedef struct packed
	{
		logic reg_write;
		logic mem_to_reg; // load data instead of alu result
	} wb_ctrl_t;

	typedef struct packed
	{
		exec_ctrl_t exec;
		mem_ctrl_t  mem;
		wb_ctrl_t   wb;
	} ctrl_t;

	// write request coming back from the write-back stage
	typedef struct packed
	{
		logic                        reg_write;
		logic [`MIPS_REG_ADDR_W-1:0] addr;
		logic [`MIPS_DATA_W-1:0]     data;
	} wb_port_t;

	// contents of the id/ex pipeline register
	typedef struct packed
	{
		logic [`MIPS_DATA_W-1:0]     pc_branch; // pc+4 for the branch adder
		logic [`MIPS_DATA_W-1:0]     sign_ext;
		logic [`MIPS_REG_ADDR_W-1:0] rs;
		logic [`MIPS_REG_ADDR_W-1:0] rt;
		logic [`MIPS_REG_ADDR_W-1:0] rd;
		logic [4:0]                  shamt;
		ctrl_t                       ctrl;
		logic                        halt;
	} id_ex_t;

endpackage

//--- src/control_unit.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module control_unit
	import mips_pkg::*;
(
	input  logic [5:0] opcode,
	input  logic [5:0] funct,
	output ctrl_t      ctrl
);

	alu_op_e r_op;    // alu op of an r-type
	logic    r_valid; // funct is one we know

	////////////////////////////////////////
	// r-type funct decode
	////////////////////////////////////////

	always_comb
	begin
		r_op    = alu_add;
		r_valid = 1'b1;
		case (funct)
			`FN_ADD: r_op = alu_add;
			`FN_SUB: r_op = alu_sub;
			`FN_AND: r_op = alu_and;
			`FN_OR:  r_op = alu_or;
			`FN_SLT: r_op = alu_slt;
			`FN_SLL: r_op = alu_sll;
			`FN_SRL: r_op = alu_srl;
			default: r_valid = 1'b0; // jr and unknown codes land here
		endcase
	end

	////////////////////////////////////////
	// opcode decode
	////////////////////////////////////////

	always_comb
	begin
		ctrl = '0; // unknown opcodes leave everything off
		case (opcode)
			`OP_RTYPE:
			begin
				if (funct == `FN_JR)
					ctrl.exec.jump_register = 1'b1; // no write back for jr
				else if (r_valid)
				begin
					ctrl.exec.reg_dst  = 1'b1;
					ctrl.exec.alu_op   = r_op;
					ctrl.wb.reg_write  = 1'b1;
				end
			end
			`OP_LW:
			begin
				ctrl.exec.alu_src  = 1'b1; // base + offset
				ctrl.exec.alu_op   = alu_add;
				ctrl.mem.mem_read  = 1'b1;
				ctrl.wb.reg_write  = 1'b1;
				ctrl.wb.mem_to_reg = 1'b1;
			end
			`OP_SW:
			begin
				ctrl.exec.alu_src  = 1'b1;
				ctrl.exec.alu_op   = alu_add;
				ctrl.mem.mem_write = 1'b1;
			end
			`OP_BEQ:
			begin
				ctrl.exec.branch = 1'b1;
				ctrl.exec.alu_op = alu_sub; // zero flag decides
			end
			`OP_BNE:
			begin
				ctrl.exec.branch    = 1'b1;
				ctrl.exec.branch_ne = 1'b1;
				ctrl.exec.alu_op    = alu_sub;
			end
			`OP_ADDI,
			`OP_SLTI,
			`OP_ANDI,
			`OP_ORI,
			`OP_LUI:
			begin
				// immediate alu ops share everything but the op
				ctrl.exec.alu_src = 1'b1;
				ctrl.wb.reg_write = 1'b1;
				case (opcode)
					`OP_SLTI: ctrl.exec.alu_op = alu_slt;
					`OP_ANDI: ctrl.exec.alu_op = alu_and;
					`OP_ORI:  ctrl.exec.alu_op = alu_or;
					`OP_LUI:  ctrl.exec.alu_op = alu_lui;
					default:  ctrl.exec.alu_op = alu_add; // addi
				endcase
			end
			`OP_J:   ctrl.exec.jump = 1'b1;
			`OP_JAL:
			begin
				ctrl.exec.jump    = 1'b1;
				ctrl.exec.link    = 1'b1; // return address into r31
				ctrl.wb.reg_write = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

//--- src/register_file.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module register_file
	import mips_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  wb_port_t                    wb,      // write port owned by write back
	input  logic [`MIPS_REG_ADDR_W-1:0] rs_addr,
	input  logic [`MIPS_REG_ADDR_W-1:0] rt_addr,
	output logic [`MIPS_DATA_W-1:0]     rs_data,
	output logic [`MIPS_DATA_W-1:0]     rt_data
);

	logic [`MIPS_DATA_W-1:0] regs [`MIPS_REG_COUNT];

	// one read port
	// r0 is hardwired and a same-cycle write is bypassed
	function automatic logic [`MIPS_DATA_W-1:0] read_reg(
		input logic [`MIPS_REG_ADDR_W-1:0] addr
	);
		logic [`MIPS_DATA_W-1:0] value;
		if (addr == '0)
			value = '0;
		else if (wb.reg_write && (wb.addr == addr))
			value = wb.data; // result retiring this cycle
		else
			value = regs[addr];
		return value;
	endfunction

	////////////////////////////////////////
	// write port
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `MIPS_REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (wb.reg_write && (wb.addr != '0))
			regs[wb.addr] <= wb.data; // r0 never written
	end

	////////////////////////////////////////
	// read ports
	////////////////////////////////////////

	always_comb
	begin
		rs_data = read_reg(rs_addr);
		rt_data = read_reg(rt_addr);
	end

endmodule

//--- src/hazard_unit.sv
`timescale 1ns/1ps
`include "mips_config.svh"

// load-use check between the load sitting in id/ex and the
// instruction now in decode
module hazard_unit
(
	input  logic                        ex_mem_read, // id/ex holds a load
	input  logic [`MIPS_REG_ADDR_W-1:0] ex_rt,       // load destination
	input  logic [`MIPS_REG_ADDR_W-1:0] rs,
	input  logic [`MIPS_REG_ADDR_W-1:0] rt,
	output logic                        hazard
);

	logic rs_match;
	logic rt_match;

	assign rs_match = (ex_rt == rs);
	assign rt_match = (ex_rt == rt);

	// data is only ready after mem
	// so one bubble covers the gap
	assign hazard = ex_mem_read && (rs_match || rt_match);

endmodule

//--- src/id_ex_stage.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module id_ex_stage
	import mips_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic [`MIPS_DATA_W-1:0] pc_branch,     // pc+4 from if/id
	input  instr_u                  instruction,
	input  wb_port_t                wb,            // retiring write back result
	input  logic                    flush,         // squash the decode slot
	input  logic                    halt,
	output id_ex_t                  id_ex,
	output logic [`MIPS_DATA_W-1:0] reg1,          // rs data
	output logic [`MIPS_DATA_W-1:0] reg2,          // rt data
	output logic [`MIPS_DATA_W-1:0] jump_target,
	output logic                    jump,
	output logic                    jump_register,
	output logic                    stall          // hold if/id one cycle
);

	ctrl_t                   dec_ctrl; // control for the current instruction
	logic [`MIPS_DATA_W-1:0] rs_data;
	logic [`MIPS_DATA_W-1:0] rt_data;
	logic                    hazard;
	id_ex_t                  id_ex_next;

	////////////////////////////////////////
	// decode blocks
	////////////////////////////////////////

	control_unit control_i
	(
		.opcode (instruction.r.opcode),
		.funct  (instruction.r.funct),
		.ctrl   (dec_ctrl)
	);

	register_file regfile_i
	(
		.clk     (clk),
		.reset   (reset),
		.wb      (wb),
		.rs_addr (instruction.r.rs),
		.rt_addr (instruction.r.rt),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	// compares against what already sits in id/ex
	hazard_unit hazard_i
	(
		.ex_mem_read (id_ex.ctrl.mem.mem_read),
		.ex_rt       (id_ex.rt),
		.rs          (instruction.r.rs),
		.rt          (instruction.r.rt),
		.hazard      (hazard)
	);

	////////////////////////////////////////
	// combinational outputs
	////////////////////////////////////////

	// all of these go quiet while the slot is flushed
	assign reg1          = flush ? '0 : rs_data;
	assign reg2          = flush ? '0 : rt_data;
	assign jump          = flush ? 1'b0 : dec_ctrl.exec.jump;
	assign jump_register = flush ? 1'b0 : dec_ctrl.exec.jump_register;
	assign stall         = flush ? 1'b0 : hazard;

	// pseudo-direct target inside the current 256MB region
	assign jump_target = flush ? '0 :
		{pc_branch[`MIPS_DATA_W-1 -: 4], instruction.j.target, 2'b00};

	////////////////////////////////////////
	// id/ex register
	////////////////////////////////////////

	always_comb
	begin
		id_ex_next.pc_branch = pc_branch;
		id_ex_next.sign_ext  = {{(`MIPS_DATA_W-16){instruction.i.imm[15]}},
			instruction.i.imm};
		id_ex_next.rs        = instruction.r.rs;
		id_ex_next.rt        = instruction.r.rt;
		id_ex_next.rd        = instruction.r.rd;
		id_ex_next.shamt     = instruction.r.shamt;
		id_ex_next.ctrl      = hazard ? '0 : dec_ctrl; // bubble on load-use
		id_ex_next.halt      = halt;
		if (flush)
		begin
			id_ex_next      = '0;
			id_ex_next.halt = halt; // halt is never squashed
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			id_ex <= '0; // no control bit live after reset
		else
			id_ex <= id_ex_next;
	end

endmodule

//--- testbench/decode_tb.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module decode_tb
	import mips_pkg::*;
();

	localparam int   max_cycles = 2000; // watchdog limit
	localparam logic hi = 1'b1;
	localparam logic lo = 1'b0;

	logic                    clk;
	logic                    reset;
	logic [`MIPS_DATA_W-1:0] pc_branch;
	instr_u                  instruction;
	wb_port_t                wb;
	logic                    flush;
	logic                    halt;
	id_ex_t                  id_ex;
	logic [`MIPS_DATA_W-1:0] reg1;
	logic [`MIPS_DATA_W-1:0] reg2;
	logic [`MIPS_DATA_W-1:0] jump_target;
	logic                    jump;
	logic                    jump_register;
	logic                    stall;

	logic [`MIPS_DATA_W-1:0] model [`MIPS_REG_COUNT]; // mirror of every register write
	logic [31:0]             rng = 32'h04e1_9ebc;
	int                      error_count = 0;
	int                      check_count = 0;

	id_ex_stage dut_i
	(
		.clk           (clk),
		.reset         (reset),
		.pc_branch     (pc_branch),
		.instruction   (instruction),
		.wb            (wb),
		.flush         (flush),
		.halt          (halt),
		.id_ex         (id_ex),
		.reg1          (reg1),
		.reg2          (reg2),
		.jump_target   (jump_target),
		.jump          (jump),
		.jump_register (jump_register),
		.stall         (stall)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// argument order follows exec, then mem, then wb fields
	function automatic ctrl_t mk_ctrl(
		input logic    reg_dst,
		input logic    alu_src,
		input alu_op_e alu_op,
		input logic    branch,
		input logic    branch_ne,
		input logic    jmp,
		input logic    jmp_reg,
		input logic    link,
		input logic    mem_read,
		input logic    mem_write,
		input logic    reg_write,
		input logic    mem_to_reg
	);
		ctrl_t c;
		c.exec.reg_dst       = reg_dst;
		c.exec.alu_src       = alu_src;
		c.exec.alu_op        = alu_op;
		c.exec.branch        = branch;
		c.exec.branch_ne     = branch_ne;
		c.exec.jump          = jmp;
		c.exec.jump_register = jmp_reg;
		c.exec.link          = link;
		c.mem.mem_read       = mem_read;
		c.mem.mem_write      = mem_write;
		c.wb.reg_write       = reg_write;
		c.wb.mem_to_reg      = mem_to_reg;
		return c;
	endfunction

	function automatic instr_u r_word(
		input logic [4:0] rs,
		input logic [4:0] rt,
		input logic [4:0] rd,
		input logic [5:0] fn
	);
		instr_u w;
		w.r.opcode = `OP_RTYPE;
		w.r.rs     = rs;
		w.r.rt     = rt;
		w.r.rd     = rd;
		w.r.shamt  = 5'd0;
		w.r.funct  = fn;
		return w;
	endfunction

	function automatic instr_u i_word(
		input logic [5:0]  op,
		input logic [4:0]  rs,
		input logic [4:0]  rt,
		input logic [15:0] imm
	);
		instr_u w;
		w.i.opcode = op;
		w.i.rs     = rs;
		w.i.rt     = rt;
		w.i.imm    = imm;
		return w;
	endfunction

	// what id/ex should hold one edge after ins was presented
	function automatic id_ex_t expect_id_ex(
		input instr_u      ins,
		input logic [31:0] pc,
		input ctrl_t       c,
		input logic        h
	);
		id_ex_t e;
		e.pc_branch = pc;
		e.sign_ext  = {{16{ins.i.imm[15]}}, ins.i.imm};
		e.rs        = ins.r.rs;
		e.rt        = ins.r.rt;
		e.rd        = ins.r.rd;
		e.shamt     = ins.r.shamt;
		e.ctrl      = c;
		e.halt      = h;
		return e;
	endfunction

	task automatic check_id_ex(input id_ex_t got, input id_ex_t exp, input string what);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] t=%0t %s: id_ex %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] t=%0t %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] t=%0t %s: got %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic tick(); // next rising edge plus drive offset
		@(posedge clk);
		#2;
	endtask

	task automatic settle();
		#5; // combinational outputs are stable well before the next edge
	endtask

	task automatic wait_for_stall(input logic level, input int limit);
		int n;
		n = 0;
		settle();
		while (stall !== level && n < limit)
		begin
			tick();
			settle();
			n++;
		end
		if (stall !== level)
		begin
			error_count++;
			$display("timeout: stall never reached %b within %0d cycles", level, limit);
		end
	endtask

	task automatic report(input string name, input int errs_before);
		if (error_count == errs_before)
			$display("test %-9s passed", name);
		else
			$display("test %-9s FAILED, %0d errors", name, error_count - errs_before);
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic test_reset();
		int errs;
		errs = error_count;
		for (int i = 0; i < 5; i++)
			tick();
		reset = lo;
		for (int r = 0; r < `MIPS_REG_COUNT; r++)
			model[r] = '0; // registers clear on reset
		settle();
		check_id_ex(id_ex, '0, "id_ex after reset");
		check_flag(stall, lo, "stall after reset");
		check_flag(jump, lo, "jump after reset");
		check_flag(jump_register, lo, "jr after reset");
		report("reset", errs);
	endtask

	task automatic test_regfile();
		int          errs;
		logic [31:0] fresh;
		errs = error_count;
		tick();
		for (int r = 1; r < `MIPS_REG_COUNT; r++)
		begin
			rng          = xorshift(rng);
			wb.reg_write = hi;
			wb.addr      = 5'(r);
			wb.data      = rng;
			model[r]     = rng;
			tick(); // written on this edge
		end
		wb.reg_write = lo;
		for (int k = 0; k < 16; k++)
		begin
			rng         = xorshift(rng);
			instruction = r_word(rng[4:0], rng[9:5], 5'd1, `FN_ADD);
			settle();
			check_word(reg1, model[rng[4:0]], "reg1 read");
			check_word(reg2, model[rng[9:5]], "reg2 read");
			tick();
		end
		// r0 write attempt seen through the bypass and after the edge
		wb.reg_write = hi;
		wb.addr      = 5'd0;
		wb.data      = 32'hdead_beef;
		instruction  = r_word(5'd0, 5'd0, 5'd0, `FN_ADD);
		settle();
		check_word(reg1, 32'h0, "r0 during write");
		tick();
		wb.reg_write = lo;
		settle();
		check_word(reg2, 32'h0, "r0 after write");
		tick();
		// same-cycle write and read
		rng          = xorshift(rng);
		fresh        = rng;
		wb.reg_write = hi;
		wb.addr      = 5'd7;
		wb.data      = fresh;
		instruction  = r_word(5'd7, 5'd7, 5'd2, `FN_OR);
		settle();
		check_word(reg1, fresh, "rs write-through");
		check_word(reg2, fresh, "rt write-through");
		model[7] = fresh;
		tick();
		wb.reg_write = lo;
		settle();
		check_word(reg1, model[7], "r7 after write");
		report("regfile", errs);
	endtask

	task automatic decode_case(
		input logic [5:0] op,
		input logic [5:0] fn,
		input ctrl_t      exp_c,
		input string      name
	);
		instr_u      ins;
		logic [31:0] pc;
		logic        h;
		instruction = '0; // nop first so no load sits in id/ex
		tick();
		rng        = xorshift(rng);
		ins        = rng; // random fields around the opcode
		ins.r.opcode = op;
		if (op == `OP_RTYPE)
			ins.r.funct = fn;
		rng         = xorshift(rng);
		pc          = {rng[31:2], 2'b00};
		h           = rng[0];
		instruction = ins;
		pc_branch   = pc;
		halt        = h;
		tick();
		check_id_ex(id_ex, expect_id_ex(ins, pc, exp_c, h), name);
		halt = lo;
	endtask

	task automatic test_decode();
		int errs;
		errs = error_count;
		decode_case(`OP_RTYPE, `FN_ADD, mk_ctrl(hi,lo,alu_add,lo,lo,lo,lo,lo, lo,lo,hi,lo), "add");
		decode_case(`OP_RTYPE, `FN_SUB, mk_ctrl(hi,lo,alu_sub,lo,lo,lo,lo,lo, lo,lo,hi,lo), "sub");
		decode_case(`OP_RTYPE, `FN_AND, mk_ctrl(hi,lo,alu_and,lo,lo,lo,lo,lo, lo,lo,hi,lo), "and");
		decode_case(`OP_RTYPE, `FN_OR,  mk_ctrl(hi,lo,alu_or,lo,lo,lo,lo,lo, lo,lo,hi,lo), "or");
		decode_case(`OP_RTYPE, `FN_SLT, mk_ctrl(hi,lo,alu_slt,lo,lo,lo,lo,lo, lo,lo,hi,lo), "slt");
		decode_case(`OP_RTYPE, `FN_SLL, mk_ctrl(hi,lo,alu_sll,lo,lo,lo,lo,lo, lo,lo,hi,lo), "sll");
		decode_case(`OP_RTYPE, `FN_SRL, mk_ctrl(hi,lo,alu_srl,lo,lo,lo,lo,lo, lo,lo,hi,lo), "srl");
		decode_case(`OP_RTYPE, `FN_JR,  mk_ctrl(lo,lo,alu_add,lo,lo,lo,hi,lo, lo,lo,lo,lo), "jr");
		decode_case(`OP_LW,   6'h0, mk_ctrl(lo,hi,alu_add,lo,lo,lo,lo,lo, hi,lo,hi,hi), "lw");
		decode_case(`OP_SW,   6'h0, mk_ctrl(lo,hi,alu_add,lo,lo,lo,lo,lo, lo,hi,lo,lo), "sw");
		decode_case(`OP_BEQ,  6'h0, mk_ctrl(lo,lo,alu_sub,hi,lo,lo,lo,lo, lo,lo,lo,lo), "beq");
		decode_case(`OP_BNE,  6'h0, mk_ctrl(lo,lo,alu_sub,hi,hi,lo,lo,lo, lo,lo,lo,lo), "bne");
		decode_case(`OP_ADDI, 6'h0, mk_ctrl(lo,hi,alu_add,lo,lo,lo,lo,lo, lo,lo,hi,lo), "addi");
		decode_case(`OP_SLTI, 6'h0, mk_ctrl(lo,hi,alu_slt,lo,lo,lo,lo,lo, lo,lo,hi,lo), "slti");
		decode_case(`OP_ANDI, 6'h0, mk_ctrl(lo,hi,alu_and,lo,lo,lo,lo,lo, lo,lo,hi,lo), "andi");
		decode_case(`OP_ORI,  6'h0, mk_ctrl(lo,hi,alu_or,lo,lo,lo,lo,lo, lo,lo,hi,lo), "ori");
		decode_case(`OP_LUI,  6'h0, mk_ctrl(lo,hi,alu_lui,lo,lo,lo,lo,lo, lo,lo,hi,lo), "lui");
		decode_case(`OP_J,    6'h0, mk_ctrl(lo,lo,alu_add,lo,lo,hi,lo,lo, lo,lo,lo,lo), "j");
		decode_case(`OP_JAL,  6'h0, mk_ctrl(lo,lo,alu_add,lo,lo,hi,lo,hi, lo,lo,hi,lo), "jal");
		decode_case(6'h3f,    6'h0, '0, "unknown op"); // nothing decodes
		report("decode", errs);
	endtask

	task automatic jump_case(input logic [5:0] op, input string name);
		logic [25:0] target;
		rng         = xorshift(rng);
		pc_branch   = {rng[31:2], 2'b00};
		rng         = xorshift(rng);
		target      = rng[25:0];
		instruction = '0;
		instruction.j.opcode = op;
		instruction.j.target = target;
		settle();
		check_flag(jump, hi, name);
		check_flag(jump_register, lo, name);
		check_word(jump_target, {pc_branch[31:28], target, 2'b00}, name);
		tick();
	endtask

	task automatic test_jumps();
		int errs;
		errs = error_count;
		jump_case(`OP_J, "j target");
		jump_case(`OP_JAL, "jal target");
		instruction = r_word(5'd9, 5'd0, 5'd0, `FN_JR);
		settle();
		check_flag(jump_register, hi, "jr flag");
		check_flag(jump, lo, "jr jump flag");
		check_word(reg1, model[9], "jr rs value");
		tick();
		report("jumps", errs);
	endtask

	////////////////////////////////////////
	// hazard and flush
	////////////////////////////////////////

	task automatic test_load_use();
		int     errs;
		instr_u add_i;
		errs        = error_count;
		instruction = i_word(`OP_LW, 5'd2, 5'd5, 16'h0010);
		tick(); // lw now in id/ex
		add_i       = r_word(5'd5, 5'd3, 5'd8, `FN_ADD);
		instruction = add_i;
		settle();
		check_flag(stall, hi, "load-use stall");
		tick();
		check_id_ex(id_ex, expect_id_ex(add_i, pc_branch, '0, lo), "bubble");
		wait_for_stall(lo, 4); // fetch still holds add
		instruction = '0;
		tick();
		instruction = i_word(`OP_LW, 5'd2, 5'd5, 16'h0010);
		tick();
		add_i       = r_word(5'd6, 5'd7, 5'd8, `FN_ADD); // no dependency on r5
		instruction = add_i;
		settle();
		check_flag(stall, lo, "independent add");
		tick();
		check_id_ex(id_ex, expect_id_ex(add_i, pc_branch,
			mk_ctrl(hi,lo,alu_add,lo,lo,lo,lo,lo, lo,lo,hi,lo), lo), "add after load");
		report("load-use", errs);
	endtask

	task automatic test_flush();
		int     errs;
		id_ex_t exp;
		errs        = error_count;
		instruction = i_word(`OP_LW, 5'd2, 5'd5, 16'h0000);
		tick();
		instruction = r_word(5'd5, 5'd5, 5'd8, `FN_ADD); // would stall
		pc_branch   = 32'hf000_0040;
		flush       = hi;
		halt        = hi;
		settle();
		check_word(reg1, 32'h0, "flushed reg1");
		check_word(reg2, 32'h0, "flushed reg2");
		check_word(jump_target, 32'h0, "flushed jump_target");
		check_flag(stall, lo, "flushed stall");
		tick();
		exp      = '0;
		exp.halt = hi; // halt survives the flush
		check_id_ex(id_ex, exp, "id_ex after flush");
		instruction = '0;
		instruction.j.opcode = `OP_J;
		instruction.j.target = 26'h3ff_ffff;
		settle();
		check_flag(jump, lo, "flushed j");
		check_word(jump_target, 32'h0, "flushed j target");
		tick();
		instruction = r_word(5'd9, 5'd9, 5'd0, `FN_JR);
		settle();
		check_flag(jump_register, lo, "flushed jr");
		tick();
		flush = lo;
		halt  = lo;
		report("flush", errs);
	endtask

	initial
	begin
		reset       = hi;
		pc_branch   = '0;
		instruction = '0;
		wb          = '0;
		flush       = lo;
		halt        = lo;
		test_reset();
		test_regfile();
		test_decode();
		test_jumps();
		test_load_use();
		test_flush();
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// stops a run that never reaches the end of the test sequence
	initial
	begin
		for (int i = 0; i < max_cycles; i++)
			@(posedge clk);
		$display("timeout: tests still running after %0d cycles", max_cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- sources.f
+incdir+src
src/mips_pkg.sv
src/control_unit.sv
src/register_file.sv
src/hazard_unit.sv
src/id_ex_stage.sv
testbench/decode_tb.sv

//--- Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decode_tb
RTL_TOP   ?= id_ex_stage
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

# the exit status comes from the grep for the pass line
run: build
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
